//--- all.f
verilog/basicOpPkg.sv
verilog/autocorrPkg.sv
verilog/scratchMemory.sv
verilog/correlationLane.sv
verilog/autocorrNormalizer.sv
verilog/autocorrPipe.sv
verification/autocorrPipe_properties.sv
verification/autocorrPipe_tb.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and judge the run from its log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module autocorrPipe_tb -f all.f \
	-o simAutocorr > build.log 2>&1 &&
./obj_dir/simAutocorr > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "TB PASSED" sim.log && echo "Simulation run: pass" ||
{ echo "Simulation run: fail (see build.log and sim.log)"; exit 1; }

//--- verification/autocorrPipe_properties.sv
module autocorrPipe_properties #(
	parameter int ORDER = autocorrPkg::DEFAULT_ORDER
) (
	input logic clk,
	input logic reset,
	input logic busy,
	input logic resultValid,
	input logic [$clog2(ORDER + 1) - 1:0] resultIndex,
	input logic done
);

	int assertFailures = 0;

	//////////////////////////////
	// Output protocol
	//////////////////////////////
	doneSingle: assert property (@(posedge clk) disable iff (reset) done |=> !done)
	else
	begin
		assertFailures++;
		$error("done stayed high for a second cycle");
	end

	indexInRange: assert property (@(posedge clk) disable iff (reset)
		resultValid |-> (int'(resultIndex) <= ORDER))
	else
	begin
		assertFailures++;
		$error("resultIndex %0d beyond the last lag", resultIndex);
	end

	// Results only inside the busy window
	validWhileBusy: assert property (@(posedge clk) disable iff (reset) resultValid |-> busy)
	else
	begin
		assertFailures++;
		$error("resultValid high while busy is low");
	end

	busyFallsAtDone: assert property (@(posedge clk) disable iff (reset) $fell(busy) |-> done)
	else
	begin
		assertFailures++;
		$error("busy fell without done");
	end

endmodule

//--- verification/autocorrPipe_tb.sv
module autocorrPipe_tb;

	localparam int FRAME_LEN = autocorrPkg::DEFAULT_FRAME_LEN;
	localparam int ORDER = autocorrPkg::DEFAULT_ORDER;
	localparam int RESET_CYCLES = 16;
	localparam int NUM_FRAMES = 8;

	// Each frame gets the MAC steps of every lag plus loading and margin
	function automatic int timeoutLimit(int frames);
		int work;
		work = 0;
		for (int k = 0; k <= ORDER; k++)
			work += FRAME_LEN - k;
		return frames * (work + 4 * FRAME_LEN) + RESET_CYCLES;
	endfunction

	localparam int TIMEOUT_CYCLES = timeoutLimit(NUM_FRAMES);

	logic clk;
	logic reset;
	logic sampleValid;
	basicOpPkg::word16_t sampleData;
	logic start;
	logic busy;
	logic resultValid;
	logic [$clog2(ORDER + 1) - 1:0] resultIndex;
	basicOpPkg::word32_t resultData;
	basicOpPkg::word16_t normShift;
	logic overflow;
	logic done;

	int cycleCount;
	int mismatchCount;
	int runErrorCount;
	logic [31:0] lfsrState;
	basicOpPkg::word16_t frame [FRAME_LEN];
	basicOpPkg::word32_t expected [ORDER + 1];
	basicOpPkg::word16_t expShift;
	logic expOverflow;

	autocorrPipe #(
		.FRAME_LEN(FRAME_LEN),
		.ORDER(ORDER)
	) u_autocorrPipe (
		.clk(clk),
		.reset(reset),
		.sampleValid(sampleValid),
		.sampleData(sampleData),
		.start(start),
		.busy(busy),
		.resultValid(resultValid),
		.resultIndex(resultIndex),
		.resultData(resultData),
		.normShift(normShift),
		.overflow(overflow),
		.done(done)
	);

	bind autocorrPipe autocorrPipe_properties #(
		.ORDER(ORDER)
	) propertyChecks (
		.clk(clk),
		.reset(reset),
		.busy(busy),
		.resultValid(resultValid),
		.resultIndex(resultIndex),
		.done(done)
	);

	always #2 clk = ~clk;

	// Run limit
	always @(posedge clk)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= TIMEOUT_CYCLES)
		begin
			$display("Run stopped after %0d cycles before the tests finished", cycleCount);
			$display("TB FAILED");
			$finish;
		end
	end

	//////////////////////////////
	// Stimulus helpers
	//////////////////////////////
	// Outputs are read and inputs driven 1 unit past the edge
	task automatic tick();
		@(posedge clk);
		#1;
	endtask

	function automatic logic [31:0] lfsrStep(logic [31:0] state);
		return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
	endfunction

	// Twelve sign-extended random bits keep r[0] clear of saturation
	function automatic basicOpPkg::word16_t randomSample();
		logic [11:0] bits;
		for (int i = 0; i < 12; i++)
		begin
			lfsrState = lfsrStep(lfsrState);
			bits[i] = lfsrState[0];
		end
		return {{4{bits[11]}}, bits};
	endfunction

	task automatic fillRamp();
		for (int n = 0; n < FRAME_LEN; n++)
			frame[n] = basicOpPkg::word16_t'((n - FRAME_LEN / 2) * 8);
	endtask

	task automatic fillRandom();
		for (int n = 0; n < FRAME_LEN; n++)
			frame[n] = randomSample();
	endtask

	task automatic fillConstant(basicOpPkg::word16_t value);
		for (int n = 0; n < FRAME_LEN; n++)
			frame[n] = value;
	endtask

	// Reference autocorrelation with the basic-operator rules
	task automatic computeModel();
		basicOpPkg::word32_t acc;
		basicOpPkg::word32_t corr [ORDER + 1];
		expOverflow = 1'b0;
		for (int k = 0; k <= ORDER; k++)
		begin
			acc = (k == 0) ? 32'sd1 : 32'sd0;
			for (int n = 0; n < FRAME_LEN - k; n++)
			begin
				if (basicOpPkg::lMacSaturates(acc, frame[n], frame[n + k]))
					expOverflow = 1'b1;
				acc = basicOpPkg::lMac(acc, frame[n], frame[n + k]);
			end
			corr[k] = acc;
		end
		expShift = basicOpPkg::normL(corr[0]);
		for (int k = 0; k <= ORDER; k++)
			expected[k] = basicOpPkg::lShl(corr[k], expShift);
	endtask

	//////////////////////////////
	// Compare tasks
	//////////////////////////////
	task automatic checkWord32(string name, basicOpPkg::word32_t actual,
		basicOpPkg::word32_t want);
		if (actual !== want)
		begin
			$display("MISMATCH %s: got %h, expected %h", name, actual, want);
			mismatchCount++;
		end
	endtask

	task automatic checkWord16(string name, basicOpPkg::word16_t actual,
		basicOpPkg::word16_t want);
		if (actual !== want)
		begin
			$display("MISMATCH %s: got %h, expected %h", name, actual, want);
			mismatchCount++;
		end
	endtask

	task automatic checkFlag(string name, logic actual, logic want);
		if (actual !== want)
		begin
			$display("MISMATCH %s: got %h, expected %h", name, actual, want);
			mismatchCount++;
		end
	endtask

	//////////////////////////////
	// Frame sequencing
	//////////////////////////////
	// Strobes beyond the frame carry full-scale data that must be dropped
	task automatic loadFrame(int extra);
		for (int n = 0; n < FRAME_LEN + extra; n++)
		begin
			tick();
			sampleValid = 1'b1;
			sampleData = (n < FRAME_LEN) ? frame[n] : 16'sh7fff;
		end
		tick();
		sampleValid = 1'b0;
	endtask

	task automatic startFrame();
		start = 1'b1;
		tick();
		start = 1'b0;
		checkFlag("busy", busy, 1'b1);
	endtask

	task automatic collectResults();
		int index;
		index = 0;
		while (index <= ORDER)
		begin
			tick();
			if (done)
			begin
				$display("done arrived after only %0d of %0d results", index, ORDER + 1);
				runErrorCount++;
			end
			if (resultValid)
			begin
				if (int'(resultIndex) != index)
				begin
					$display("Result index %0d came where index %0d was due", resultIndex, index);
					runErrorCount++;
				end
				checkWord32($sformatf("resultData[%0d]", index), resultData, expected[index]);
				checkWord16("normShift", normShift, expShift);
				index++;
			end
		end
		tick();
		if (!done)
		begin
			$display("done did not pulse in the cycle after the last result");
			runErrorCount++;
		end
		checkFlag("busy", busy, 1'b0);
		checkFlag("overflow", overflow, expOverflow);
	endtask

	task automatic runFrame();
		computeModel();
		loadFrame(0);
		startFrame();
		collectResults();
	endtask

	//////////////////////////////
	// Directed tests
	//////////////////////////////
	task automatic testIdleAfterReset();
		repeat (8)
		begin
			tick();
			checkFlag("busy", busy, 1'b0);
			checkFlag("resultValid", resultValid, 1'b0);
			checkFlag("done", done, 1'b0);
			checkFlag("overflow", overflow, 1'b0);
		end
	endtask

	task automatic testRamp();
		fillRamp();
		runFrame();
		checkFlag("overflow", overflow, 1'b0);
	endtask

	task automatic testRandom();
		fillRandom();
		runFrame();
	endtask

	// An r[0] of 1 normalizes by 30 and every other lag stays 0
	task automatic testZero();
		fillConstant(16'sd0);
		loadFrame(0);
		expShift = 16'sd30;
		expOverflow = 1'b0;
		expected[0] = 32'sh4000_0000;
		for (int k = 1; k <= ORDER; k++)
			expected[k] = 32'sd0;
		startFrame();
		collectResults();
	endtask

	task automatic testFullScale();
		fillConstant(16'sh8000);
		runFrame();
		checkFlag("overflow", overflow, 1'b1);
		fillRamp();
		runFrame();
	endtask

	// Enough extra strobes to wrap a write address that kept counting
	task automatic testBusyIgnores();
		fillRandom();
		computeModel();
		loadFrame(20);
		startFrame();
		for (int i = 0; i < 20; i++)
		begin
			sampleValid = 1'b1;
			sampleData = 16'sh7fff;
			start = (i == 5);
			tick();
		end
		sampleValid = 1'b0;
		start = 1'b0;
		collectResults();
	endtask

	task automatic testBackToBack();
		repeat (2)
		begin
			fillRandom();
			runFrame();
		end
	endtask

	initial
	begin
		clk = 1'b0;
		reset = 1'b1;
		sampleValid = 1'b0;
		sampleData = '0;
		start = 1'b0;
		cycleCount = 0;
		mismatchCount = 0;
		runErrorCount = 0;
		lfsrState = 32'hdea0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		reset = 1'b0;
		testIdleAfterReset();
		testRamp();
		testRandom();
		testZero();
		testFullScale();
		testBusyIgnores();
		testBackToBack();
		$display("Error counts: %0d mismatches, %0d run errors, %0d assertion failures",
			mismatchCount, runErrorCount, u_autocorrPipe.propertyChecks.assertFailures);
		if (mismatchCount + runErrorCount + u_autocorrPipe.propertyChecks.assertFailures == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

//--- verilog/autocorrNormalizer.sv
module autocorrNormalizer #(
	parameter int ORDER = autocorrPkg::DEFAULT_ORDER
) (
	input logic clk,
	input logic reset,
	input logic start,
	input logic evenValid,
	input logic oddValid,
	input logic [$clog2(ORDER + 1) - 1:0] evenIndex,
	input logic [$clog2(ORDER + 1) - 1:0] oddIndex,
	input basicOpPkg::word32_t evenValue,
	input basicOpPkg::word32_t oddValue,
	input logic evenOverflow,
	input logic oddOverflow,
	input logic evenDone,
	input logic oddDone,
	output logic busy,
	output logic resultValid,
	output logic [$clog2(ORDER + 1) - 1:0] resultIndex,
	output basicOpPkg::word32_t resultData,
	output basicOpPkg::word16_t normShift,
	output logic overflow,
	output logic done
);

	localparam int INDEX_W = $clog2(ORDER + 1);

	typedef enum logic [1:0] {IDLE, COLLECT, PLAY, LAST} state_t;

	state_t state;
	logic evenSeen;
	logic oddSeen;
	logic bothDone;
	logic holdValid;
	logic [INDEX_W - 1:0] holdIndex;
	basicOpPkg::word32_t holdValue;
	logic writeEnable;
	logic [INDEX_W - 1:0] writeAddress;
	basicOpPkg::word32_t writeData;
	logic [INDEX_W - 1:0] playIndex;
	basicOpPkg::word32_t readData;
	basicOpPkg::word32_t r0;

	assign bothDone = evenSeen && oddSeen;

	//////////////////////////////
	// Lane merge
	//////////////////////////////
	// Even wins a collision, the odd value goes through the holding register
	always_comb
	begin
		writeEnable = evenValid || oddValid || holdValid;
		if (evenValid)
		begin
			writeAddress = evenIndex;
			writeData = evenValue;
		end
		else if (holdValid)
		begin
			writeAddress = holdIndex;
			writeData = holdValue;
		end
		else
		begin
			writeAddress = oddIndex;
			writeData = oddValue;
		end
	end

	scratchMemory #(
		.DEPTH(ORDER + 1),
		.payload_t(basicOpPkg::word32_t)
	) coefficients (
		.clk(clk),
		.writeEnable(writeEnable),
		.writeAddress(writeAddress),
		.writeData(writeData),
		.readAddressA(playIndex),
		.readDataA(readData),
		.readAddressB('0),
		.readDataB()
	);

	// Playback through the saturating shift
	assign resultData = basicOpPkg::lShl(readData, normShift);

	//////////////////////////////
	// Frame control
	//////////////////////////////
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= IDLE;
			busy <= 1'b0;
			done <= 1'b0;
			resultValid <= 1'b0;
			overflow <= 1'b0;
			evenSeen <= 1'b0;
			oddSeen <= 1'b0;
			holdValid <= 1'b0;
		end
		else
		begin
			done <= (state == LAST);
			resultValid <= (state == PLAY);
			holdValid <= evenValid && oddValid;
			case (state)
				IDLE:
				begin
					if (start)
					begin
						state <= COLLECT;
						busy <= 1'b1;
						overflow <= 1'b0;
						evenSeen <= 1'b0;
						oddSeen <= 1'b0;
					end
				end
				COLLECT:
				begin
					overflow <= overflow || evenOverflow || oddOverflow;
					if (evenDone)
						evenSeen <= 1'b1;
					if (oddDone)
						oddSeen <= 1'b1;
					if (bothDone)
						state <= PLAY;
				end
				PLAY: if (playIndex == INDEX_W'(ORDER)) state <= LAST;
				LAST:
				begin
					state <= IDLE;
					busy <= 1'b0;
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Coefficient bookkeeping
	always_ff @(posedge clk)
	begin
		if (evenValid && evenIndex == '0)
			r0 <= evenValue;
		if (evenValid && oddValid)
		begin
			holdIndex <= oddIndex;
			holdValue <= oddValue;
		end
		if (state == COLLECT && bothDone)
		begin
			normShift <= basicOpPkg::normL(r0);
			playIndex <= '0;
		end
		else if (state == PLAY)
			playIndex <= playIndex + 1'b1;
		resultIndex <= playIndex;
	end

endmodule

//--- verilog/autocorrPipe.sv
module autocorrPipe #(
	parameter int FRAME_LEN = autocorrPkg::DEFAULT_FRAME_LEN,
	parameter int ORDER = autocorrPkg::DEFAULT_ORDER
) (
	input logic clk,
	input logic reset,
	input logic sampleValid,
	input basicOpPkg::word16_t sampleData,
	input logic start,
	output logic busy,
	output logic resultValid,
	output logic [$clog2(ORDER + 1) - 1:0] resultIndex,
	output basicOpPkg::word32_t resultData,
	output basicOpPkg::word16_t normShift,
	output logic overflow,
	output logic done
);

	localparam int INDEX_W = $clog2(ORDER + 1);

	logic evenValid;
	logic [INDEX_W - 1:0] evenIndex;
	basicOpPkg::word32_t evenValue;
	logic evenOverflow;
	logic evenDone;
	logic oddValid;
	logic [INDEX_W - 1:0] oddIndex;
	basicOpPkg::word32_t oddValue;
	logic oddOverflow;
	logic oddDone;

	//////////////////////////////
	// Even and odd lag lanes
	//////////////////////////////
	correlationLane #(
		.FRAME_LEN(FRAME_LEN),
		.ORDER(ORDER),
		.FIRST_LAG(0)
	) laneEven (
		.clk(clk),
		.reset(reset),
		.sampleValid(sampleValid),
		.sampleData(sampleData),
		.start(start),
		.lagValid(evenValid),
		.lagIndex(evenIndex),
		.lagValue(evenValue),
		.laneOverflow(evenOverflow),
		.laneDone(evenDone)
	);

	correlationLane #(
		.FRAME_LEN(FRAME_LEN),
		.ORDER(ORDER),
		.FIRST_LAG(1)
	) laneOdd (
		.clk(clk),
		.reset(reset),
		.sampleValid(sampleValid),
		.sampleData(sampleData),
		.start(start),
		.lagValid(oddValid),
		.lagIndex(oddIndex),
		.lagValue(oddValue),
		.laneOverflow(oddOverflow),
		.laneDone(oddDone)
	);

	// Merge, normL of r[0] and playback
	autocorrNormalizer #(
		.ORDER(ORDER)
	) normalizer (
		.clk(clk),
		.reset(reset),
		.start(start),
		.evenValid(evenValid),
		.oddValid(oddValid),
		.evenIndex(evenIndex),
		.oddIndex(oddIndex),
		.evenValue(evenValue),
		.oddValue(oddValue),
		.evenOverflow(evenOverflow),
		.oddOverflow(oddOverflow),
		.evenDone(evenDone),
		.oddDone(oddDone),
		.busy(busy),
		.resultValid(resultValid),
		.resultIndex(resultIndex),
		.resultData(resultData),
		.normShift(normShift),
		.overflow(overflow),
		.done(done)
	);

endmodule

//--- verilog/autocorrPkg.sv
package autocorrPkg;

	localparam int DEFAULT_FRAME_LEN = 240;
	localparam int DEFAULT_ORDER = 10;

	// Sample address and lag index widths at the defaults
	localparam int DEFAULT_ADDR_W = $clog2(DEFAULT_FRAME_LEN);
	localparam int DEFAULT_INDEX_W = $clog2(DEFAULT_ORDER + 1);

	// Cycles one lane spends on its lags, fill and strobe included
	function automatic int laneCycles(int frameLen, int order, int firstLag);
		int total;
		total = 0;
		for (int lag = firstLag; lag <= order; lag += 2)
			total += frameLen - lag + 2;
		return total;
	endfunction

	// Busy window of a frame covers the slower lane, done pickup, normL and playback
	function automatic int frameCycles(int frameLen, int order);
		int evenCycles;
		int oddCycles;
		evenCycles = laneCycles(frameLen, order, 0);
		oddCycles = laneCycles(frameLen, order, 1);
		return ((evenCycles > oddCycles) ? evenCycles : oddCycles) + order + 4;
	endfunction

endpackage

//--- verilog/basicOpPkg.sv
package basicOpPkg;

	typedef logic signed [15:0] word16_t;
	typedef logic signed [31:0] word32_t;

	localparam word32_t MAX_32 = 32'sh7fff_ffff;
	localparam word32_t MIN_32 = 32'sh8000_0000;

	// Doubled product of L_mult, which clamps only for -32768 squared
	function automatic word32_t lMult(word16_t a, word16_t b);
		word32_t product;
		product = a * b;
		if (product == 32'sh4000_0000)
			return MAX_32;
		return product <<< 1;
	endfunction

	// Unclamped sum of accumulator and doubled product
	function automatic logic signed [33:0] macSum(word32_t acc, word16_t a, word16_t b);
		logic signed [33:0] wideAcc;
		logic signed [33:0] wideProduct;
		wideAcc = acc;
		wideProduct = lMult(a, b);
		return wideAcc + wideProduct;
	endfunction

	function automatic word32_t lMac(word32_t acc, word16_t a, word16_t b);
		logic signed [33:0] sum;
		sum = macSum(acc, a, b);
		if (sum > MAX_32)
			return MAX_32;
		if (sum < MIN_32)
			return MIN_32;
		return sum[31:0];
	endfunction

	// A doubled product is even, so MAX_32 out of lMult means it clamped
	function automatic logic lMacSaturates(word32_t acc, word16_t a, word16_t b);
		logic signed [33:0] sum;
		sum = macSum(acc, a, b);
		return (lMult(a, b) == MAX_32) || (sum > MAX_32) || (sum < MIN_32);
	endfunction

	function automatic word32_t lShl(word32_t value, word16_t shift);
		word32_t result;
		result = value;
		// Negative count means arithmetic right shift
		if (shift <= 0)
			return value >>> (-shift);
		for (int i = 0; i < 32; i++)
		begin
			if (i < shift)
			begin
				if (result > 32'sh3fff_ffff)
					result = MAX_32;
				else if (result < 32'shc000_0000)
					result = MIN_32;
				else
					result = result <<< 1;
			end
		end
		return result;
	endfunction

	function automatic word16_t normL(word32_t value);
		word32_t magnitude;
		word16_t count;
		logic found;
		magnitude = value[31] ? ~value : value;
		count = 16'sd0;
		found = 1'b0;
		// Redundant sign bits below bit 31
		for (int i = 30; i >= 0; i--)
		begin
			if (!found)
			begin
				if (magnitude[i])
					found = 1'b1;
				else
					count = count + 16'sd1;
			end
		end
		return (value == 0) ? 16'sd0 : count;
	endfunction

endpackage

//--- verilog/correlationLane.sv
module correlationLane #(
	parameter int FRAME_LEN = autocorrPkg::DEFAULT_FRAME_LEN,
	parameter int ORDER = autocorrPkg::DEFAULT_ORDER,
	parameter int FIRST_LAG = 0
) (
	input logic clk,
	input logic reset,
	input logic sampleValid,
	input basicOpPkg::word16_t sampleData,
	input logic start,
	output logic lagValid,
	output logic [$clog2(ORDER + 1) - 1:0] lagIndex,
	output basicOpPkg::word32_t lagValue,
	output logic laneOverflow,
	output logic laneDone
);

	localparam int ADDR_W = $clog2(FRAME_LEN);
	localparam int INDEX_W = $clog2(ORDER + 1);
	localparam int BUSY_CYCLES = autocorrPkg::frameCycles(FRAME_LEN, ORDER);
	localparam int COUNT_W = $clog2(BUSY_CYCLES);

	typedef enum logic [1:0] {IDLE, READ, FLUSH, EMIT} phase_t;

	phase_t phase;
	logic frameBusy;
	logic [COUNT_W - 1:0] frameCount;
	logic [ADDR_W:0] writeCount;
	logic sampleAccept;
	logic startAccept;
	logic [INDEX_W - 1:0] lag;
	logic [ADDR_W - 1:0] readIndex;
	logic [ADDR_W - 1:0] readAddressB;
	logic readValid;
	logic lastRead;
	logic lastLag;
	basicOpPkg::word16_t readDataA;
	basicOpPkg::word16_t readDataB;
	basicOpPkg::word32_t acc;

	assign sampleAccept = sampleValid && !frameBusy && (writeCount < (ADDR_W + 1)'(FRAME_LEN));
	assign startAccept = start && !frameBusy;
	assign readAddressB = readIndex + ADDR_W'(lag);
	assign lastRead = (readAddressB == ADDR_W'(FRAME_LEN - 1));
	assign lastLag = (int'(lag) + 2 > ORDER);

	assign lagValid = (phase == EMIT);
	assign lagIndex = lag;
	assign lagValue = acc;

	scratchMemory #(
		.DEPTH(FRAME_LEN),
		.payload_t(basicOpPkg::word16_t)
	) samples (
		.clk(clk),
		.writeEnable(sampleAccept),
		.writeAddress(writeCount[ADDR_W - 1:0]),
		.writeData(sampleData),
		.readAddressA(readIndex),
		.readDataA(readDataA),
		.readAddressB(readAddressB),
		.readDataB(readDataB)
	);

	//////////////////////////////
	// Frame window
	//////////////////////////////
	// The lane sees no done, so it times the whole busy window itself
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			frameBusy <= 1'b0;
			frameCount <= '0;
			writeCount <= '0;
		end
		else if (!frameBusy)
		begin
			if (sampleAccept)
				writeCount <= writeCount + 1'b1;
			if (start)
			begin
				frameBusy <= 1'b1;
				frameCount <= '0;
			end
		end
		else if (frameCount == COUNT_W'(BUSY_CYCLES - 1))
		begin
			frameBusy <= 1'b0;
			writeCount <= '0;
		end
		else
			frameCount <= frameCount + 1'b1;
	end

	//////////////////////////////
	// Lag sequencer
	//////////////////////////////
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			phase <= IDLE;
			readValid <= 1'b0;
			laneDone <= 1'b0;
			laneOverflow <= 1'b0;
		end
		else
		begin
			readValid <= (phase == READ);
			laneDone <= (phase == EMIT) && lastLag;
			if (startAccept)
				laneOverflow <= 1'b0;
			else if (readValid && basicOpPkg::lMacSaturates(acc, readDataA, readDataB))
				laneOverflow <= 1'b1;
			case (phase)
				IDLE: if (startAccept) phase <= READ;
				READ: if (lastRead) phase <= FLUSH;
				FLUSH: phase <= EMIT;
				EMIT: phase <= lastLag ? IDLE : READ;
				default: phase <= IDLE;
			endcase
		end
	end

	// MAC datapath
	always_ff @(posedge clk)
	begin
		if (startAccept)
		begin
			lag <= INDEX_W'(FIRST_LAG);
			readIndex <= '0;
			acc <= (FIRST_LAG == 0) ? 32'sd1 : 32'sd0;
		end
		else if (phase == EMIT)
		begin
			lag <= lag + INDEX_W'(2);
			readIndex <= '0;
			// Lag 0 is only ever the first one
			acc <= 32'sd0;
		end
		else
		begin
			if (phase == READ)
				readIndex <= readIndex + 1'b1;
			if (readValid)
				acc <= basicOpPkg::lMac(acc, readDataA, readDataB);
		end
	end

endmodule

//--- verilog/scratchMemory.sv
module scratchMemory #(
	parameter int DEPTH = 16,
	parameter type payload_t = logic [15:0]
) (
	input logic clk,
	input logic writeEnable,
	input logic [$clog2(DEPTH) - 1:0] writeAddress,
	input payload_t writeData,
	input logic [$clog2(DEPTH) - 1:0] readAddressA,
	output payload_t readDataA,
	input logic [$clog2(DEPTH) - 1:0] readAddressB,
	output payload_t readDataB
);

	payload_t storage [DEPTH];

	// Registered reads return old data on a same-address write
	always_ff @(posedge clk)
	begin
		if (writeEnable)
			storage[writeAddress] <= writeData;
		readDataA <= storage[readAddressA];
		readDataB <= storage[readAddressB];
	end

endmodule
